//--- bench/tb_hc_afu.sv
// Testbench for the host-copy accelerator.
// Models host memory with random latency and back-pressure and checks copies and DSM records.
`timescale 1ns/1ps
`default_nettype none

module tb_hc_afu import hc_pkg::*; ();

  localparam int BUF_DEPTH = 16;
  // One lone job plus eight back-to-back jobs
  localparam int JOBS = 9;
  localparam int WATCHDOG_CYCLES = JOBS * (BUF_DEPTH * 40 + 200) + 100;
  localparam logic [31:0] SEED = 32'h9dd9261d;

  logic        clk;
  logic        rst;
  t_mmio_req   mmio_req;
  t_mmio_rsp   mmio_rsp;
  t_mem_rd_req rd_req;
  t_mem_rd_rsp rd_rsp;
  logic        rd_alm_full;
  t_mem_wr_req wr_req;
  logic        wr_ack;
  logic        wr_alm_full;

  // Separate generator states keep the stimulus independent of the memory model
  logic [31:0] stim_seed;
  logic [31:0] model_seed;

  // Sparse host memory, indexed by line address
  t_hc_line    host_mem [t_hc_address];

  // Descriptor of the job in flight, as the model expects it
  t_hc_address cur_src;
  t_hc_address cur_dst;
  t_hc_address cur_dsm;
  t_hc_length  cur_len;
  bit          tag_seen [256];
  int          rd_count;
  int          wr_count;
  int          acks_seen;
  bit          dsm_acked;
  int          cyc;

  // Outstanding reads and writes waiting for their answer
  t_hc_tag     rq_tag [$];
  t_hc_address rq_addr [$];
  int          rq_due [$];
  int          ack_due [$];
  bit          ack_dsm [$];

  hc_afu_top #(.BUF_DEPTH(BUF_DEPTH)) dut (
    .clk         (clk),
    .rst         (rst),
    .mmio_req    (mmio_req),
    .mmio_rsp    (mmio_rsp),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp),
    .rd_alm_full (rd_alm_full),
    .wr_req      (wr_req),
    .wr_ack      (wr_ack),
    .wr_alm_full (wr_alm_full)
  );

  always #4 clk = ~clk;

  // LCG step, halves swapped so small moduli see the well-mixed upper bits
  function automatic logic [31:0] next_rand(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return {state[15:0], state[31:16]};
  endfunction

  // Lines never written read back as a pattern built from the whole address
  function automatic t_hc_line line_at(input t_hc_address addr);
    t_hc_line line;
    if (host_mem.exists(addr)) begin
      line = host_mem[addr];
    end else begin
      line = {addr, ~addr};
    end
    return line;
  endfunction

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Register tasks are entered and left 1 ns after a rising edge
  task automatic write_reg(input t_hc_reg_addr addr, input t_hc_reg data);
    mmio_req.wr   = 1'b1;
    mmio_req.addr = addr;
    mmio_req.data = data;
    @(posedge clk);
    #1;
    mmio_req.wr = 1'b0;
  endtask

  task automatic read_reg(input t_hc_reg_addr addr, output t_hc_reg data);
    mmio_req.rd   = 1'b1;
    mmio_req.addr = addr;
    @(posedge clk);
    #1;
    mmio_req.rd = 1'b0;
    // The answer must be there exactly one cycle after the strobe
    expect_equal("mmio_rsp.valid", 64'(mmio_rsp.valid), 64'd1);
    data = mmio_rsp.data;
  endtask

  // Host memory model, samples at the edge and drives 1 ns later
  always @(posedge clk) begin
    int pick;
    int sel;
    int n_due;
    int due;
    cyc = cyc + 1;
    if (!rst) begin
      expect_equal("rd_req.valid under rd_alm_full", 64'(rd_req.valid & rd_alm_full), 64'd0);
      expect_equal("wr_req.valid under wr_alm_full", 64'(wr_req.valid & wr_alm_full), 64'd0);
      if (rd_req.valid) begin
        // Each tag names one line of the job and is asked for once
        expect_equal("rd_req.tag in range", 64'(rd_req.tag < cur_len), 64'd1);
        expect_equal("rd_req.tag repeated", 64'(tag_seen[rd_req.tag]), 64'd0);
        expect_equal("rd_req.addr", 64'(rd_req.addr), 64'(cur_src + t_hc_address'(rd_req.tag)));
        tag_seen[rd_req.tag] = 1'b1;
        rd_count = rd_count + 1;
        rq_tag.push_back(rd_req.tag);
        rq_addr.push_back(rd_req.addr);
        rq_due.push_back(cyc + 1 + int'(next_rand(model_seed) % 32'd8));
      end
      if (wr_req.valid) begin
        if (wr_req.addr == cur_dsm) begin
          // Only acks seen at earlier edges could have released the DSM write
          expect_equal("data acks before DSM write", 64'(acks_seen), 64'(cur_len));
          expect_equal("data writes before DSM write", 64'(wr_count), 64'(cur_len));
        end else begin
          expect_equal("wr_req.addr in range",
                       64'((wr_req.addr - cur_dst) < t_hc_address'(cur_len)), 64'd1);
          wr_count = wr_count + 1;
        end
        host_mem[wr_req.addr] = wr_req.data;
        // Acks stay in order, so a write never overtakes the one before it
        due = cyc + 1 + int'(next_rand(model_seed) % 32'd4);
        if (ack_due.size() > 0 && due <= ack_due[ack_due.size() - 1]) begin
          due = ack_due[ack_due.size() - 1] + 1;
        end
        ack_due.push_back(due);
        ack_dsm.push_back(wr_req.addr == cur_dsm);
      end
      if (wr_ack) begin
        acks_seen = acks_seen + 1;
      end
    end
    #1;
    rd_rsp = '0;
    n_due  = 0;
    foreach (rq_due[i]) begin
      if (rq_due[i] <= cyc) begin
        n_due = n_due + 1;
      end
    end
    // Answer one random read among those whose latency has run out
    if (n_due > 0) begin
      pick = int'(next_rand(model_seed) % 32'(n_due));
      sel  = 0;
      for (int i = 0; i < rq_due.size(); i++) begin
        if (rq_due[i] <= cyc) begin
          if (pick == 0) begin
            sel = i;
            break;
          end
          pick = pick - 1;
        end
      end
      rd_rsp.valid = 1'b1;
      rd_rsp.tag   = rq_tag[sel];
      rd_rsp.data  = line_at(rq_addr[sel]);
      rq_tag.delete(sel);
      rq_addr.delete(sel);
      rq_due.delete(sel);
    end
    wr_ack = 1'b0;
    if (ack_due.size() > 0 && ack_due[0] <= cyc) begin
      wr_ack = 1'b1;
      if (ack_dsm[0]) begin
        dsm_acked = 1'b1;
      end
      void'(ack_due.pop_front());
      void'(ack_dsm.pop_front());
    end
    // Roughly one cycle in five is back-pressured on each channel
    rd_alm_full = (next_rand(model_seed) % 32'd10) < 32'd2;
    wr_alm_full = (next_rand(model_seed) % 32'd10) < 32'd2;
  end

  // One copy job with fresh bases, checked line by line after the DSM ack
  task automatic run_job(input int n);
    logic [31:0] r;
    t_hc_reg     status;
    t_hc_line    line;
    t_hc_line    expect_q [$];
    r = next_rand(stim_seed);
    cur_src = {4'h1, r[27:0]};
    r = next_rand(stim_seed);
    cur_dst = {4'h5, r[27:0]};
    r = next_rand(stim_seed);
    cur_dsm = {4'h9, r[27:0]};
    cur_len = t_hc_length'(n);
    for (int i = 0; i < n; i++) begin
      line = {next_rand(stim_seed), next_rand(stim_seed)};
      expect_q.push_back(line);
      host_mem[cur_src + t_hc_address'(i)] = line;
      host_mem.delete(cur_dst + t_hc_address'(i));
    end
    // The line just past the destination must stay absent
    host_mem.delete(cur_dst + t_hc_address'(n));
    host_mem.delete(cur_dsm);
    foreach (tag_seen[i]) begin
      tag_seen[i] = 1'b0;
    end
    rd_count  = 0;
    wr_count  = 0;
    acks_seen = 0;
    dsm_acked = 1'b0;
    write_reg(HC_REG_DSM, cur_dsm);
    write_reg(HC_REG_SRC, cur_src);
    write_reg(HC_REG_DST, cur_dst);
    write_reg(HC_REG_LEN, t_hc_reg'(cur_len));
    write_reg(HC_REG_CTRL, 32'd1);
    read_reg(HC_REG_STATUS, status);
    expect_equal("status after go", 64'(status), 64'd1);
    // The flag changes 1 ns after an edge, so it is polled on the edge
    @(posedge clk);
    while (!dsm_acked) begin
      @(posedge clk);
    end
    #1;
    read_reg(HC_REG_STATUS, status);
    expect_equal("status after DSM ack", 64'(status), 64'd2);
    expect_equal("read requests per job", 64'(rd_count), 64'(n));
    expect_equal("data writes per job", 64'(wr_count), 64'(n));
    for (int i = 0; i < n; i++) begin
      expect_equal($sformatf("dst line %0d", i), line_at(cur_dst + t_hc_address'(i)),
                   expect_q[i]);
    end
    expect_equal("line past dst written", 64'(host_mem.exists(cur_dst + t_hc_address'(n))),
                 64'd0);
    line = line_at(cur_dsm);
    expect_equal("dsm line upper half", 64'(line[63:32]), 64'(HC_DSM_DONE));
    expect_equal("dsm line length byte", 64'(line[7:0]), 64'(cur_len));
  endtask

  initial begin
    t_hc_reg rdata;
    t_hc_reg vals [4];
    clk         = 1'b0;
    rst         = 1'b1;
    mmio_req    = '0;
    rd_rsp      = '0;
    rd_alm_full = 1'b0;
    wr_ack      = 1'b0;
    wr_alm_full = 1'b0;
    stim_seed   = SEED;
    model_seed  = SEED;
    cur_src     = '0;
    cur_dst     = '0;
    cur_dsm     = '1;
    cur_len     = '0;
    cyc         = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet outputs after reset
    for (int i = 0; i < 10; i++) begin
      expect_equal("rd_req.valid after reset", 64'(rd_req.valid), 64'd0);
      expect_equal("wr_req.valid after reset", 64'(wr_req.valid), 64'd0);
      expect_equal("mmio_rsp.valid after reset", 64'(mmio_rsp.valid), 64'd0);
      @(posedge clk);
      #1;
    end
    read_reg(HC_REG_STATUS, rdata);
    expect_equal("status after reset", 64'(rdata), 64'd0);

    // Descriptor registers read back what was written, the length keeps one byte
    for (int i = 0; i < 4; i++) begin
      vals[i] = next_rand(stim_seed);
      if (i == 3) begin
        vals[i] = vals[i] & 32'h0000_00ff;
      end
      write_reg(t_hc_reg_addr'(i), vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(t_hc_reg_addr'(i), rdata);
      expect_equal($sformatf("register %0d readback", i), 64'(rdata), 64'(vals[i]));
    end
    for (int a = 4; a < 16; a++) begin
      if (a != int'(HC_REG_STATUS)) begin
        read_reg(t_hc_reg_addr'(a), rdata);
        expect_equal($sformatf("unmapped register %0d", a), 64'(rdata), 64'd0);
      end
    end

    for (int j = 0; j < JOBS; j++) begin
      run_job(1 + int'(next_rand(stim_seed) % 32'(BUF_DEPTH)));
    end

    $display("TEST PASS");
    $finish;
  end

  // Ends a run that stops making progress
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles before all jobs completed", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

endmodule : tb_hc_afu

`default_nettype wire

//--- hdl/hc_afu_top.sv
// Top level of the host-copy accelerator.
// Wires the register file, requestor, line buffer and loopback core together.
`timescale 1ns/1ps
`default_nettype none

module hc_afu_top import hc_pkg::*; #(
  parameter int BUF_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  t_mmio_req   mmio_req,
  output t_mmio_rsp   mmio_rsp,
  output t_mem_rd_req rd_req,
  input  t_mem_rd_rsp rd_rsp,
  input  logic        rd_alm_full,
  output t_mem_wr_req wr_req,
  input  logic        wr_ack,
  input  logic        wr_alm_full
);

  logic        go;
  logic        busy;
  logic        done;
  t_hc_control hc_control;
  logic        start;
  logic        finish;
  t_hc_length  num_lines;

  // Requestor side of the line buffer
  logic        in_we;
  t_hc_tag     in_idx;
  t_hc_line    in_data;
  t_hc_tag     out_idx;
  t_hc_line    out_data;

  // Core side of the line buffer
  t_hc_tag     core_rd_idx;
  t_hc_line    core_rd_data;
  logic        core_wr_en;
  t_hc_tag     core_wr_idx;
  t_hc_line    core_wr_data;

  hc_csr u_hc_csr (
    .clk        (clk),
    .rst        (rst),
    .mmio_req   (mmio_req),
    .mmio_rsp   (mmio_rsp),
    .busy       (busy),
    .done       (done),
    .go         (go),
    .hc_control (hc_control)
  );

  hc_requestor #(.BUF_DEPTH(BUF_DEPTH)) u_hc_requestor (
    .clk         (clk),
    .rst         (rst),
    .go          (go),
    .hc_control  (hc_control),
    .busy        (busy),
    .done        (done),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp),
    .rd_alm_full (rd_alm_full),
    .wr_req      (wr_req),
    .wr_ack      (wr_ack),
    .wr_alm_full (wr_alm_full),
    .in_we       (in_we),
    .in_idx      (in_idx),
    .in_data     (in_data),
    .out_idx     (out_idx),
    .out_data    (out_data),
    .start       (start),
    .num_lines   (num_lines),
    .finish      (finish)
  );

  hc_core_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_hc_core_buffer (
    .clk             (clk),
    .req_in_we       (in_we),
    .req_in_idx      (in_idx),
    .req_in_data     (in_data),
    .core_in_idx     (core_rd_idx),
    .core_in_data    (core_rd_data),
    .core_out_we     (core_wr_en),
    .core_out_idx    (core_wr_idx),
    .core_out_data_w (core_wr_data),
    .req_out_idx     (out_idx),
    .req_out_data    (out_data)
  );

  hc_loopback #(.BUF_DEPTH(BUF_DEPTH)) u_hc_loopback (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .num_lines (num_lines),
    .finish    (finish),
    .rd_idx    (core_rd_idx),
    .rd_data   (core_rd_data),
    .wr_en     (core_wr_en),
    .wr_idx    (core_wr_idx),
    .wr_data   (core_wr_data)
  );

endmodule : hc_afu_top

`default_nettype wire

//--- hdl/hc_core_buffer.sv
// Line buffer between the requestor and the core.
// Bank 0 holds input lines and bank 1 output lines, each read with one cycle latency.
`timescale 1ns/1ps
`default_nettype none

module hc_core_buffer import hc_pkg::*; #(
  parameter int BUF_DEPTH = 16
) (
  input  logic     clk,
  input  logic     req_in_we,
  input  t_hc_tag  req_in_idx,
  input  t_hc_line req_in_data,
  input  t_hc_tag  core_in_idx,
  output t_hc_line core_in_data,
  input  logic     core_out_we,
  input  t_hc_tag  core_out_idx,
  input  t_hc_line core_out_data_w,
  input  t_hc_tag  req_out_idx,
  output t_hc_line req_out_data
);

  localparam int IW = $clog2(BUF_DEPTH);

  // Per-bank port views, index 0 is the input bank and 1 the output bank
  logic     we    [2];
  t_hc_tag  widx  [2];
  t_hc_tag  ridx  [2];
  t_hc_line wdata [2];
  t_hc_line rdata [2];

  // The requestor fills bank 0 and the core drains it
  assign we[0]    = req_in_we;
  assign widx[0]  = req_in_idx;
  assign wdata[0] = req_in_data;
  assign ridx[0]  = core_in_idx;
  assign core_in_data = rdata[0];

  // The core fills bank 1 and the requestor drains it
  assign we[1]    = core_out_we;
  assign widx[1]  = core_out_idx;
  assign wdata[1] = core_out_data_w;
  assign ridx[1]  = req_out_idx;
  assign req_out_data = rdata[1];

  for (genvar b = 0; b < 2; b++) begin : g_bank
    t_hc_line mem [BUF_DEPTH];

    // Only the low index bits address the bank
    always_ff @(posedge clk) begin
      if (we[b]) begin
        mem[widx[b][IW-1:0]] <= wdata[b];
      end
      rdata[b] <= mem[ridx[b][IW-1:0]];
    end
  end

endmodule : hc_core_buffer

`default_nettype wire

//--- hdl/hc_csr.sv
// Register file of the host-copy accelerator.
// Holds the job descriptor, raises go on a control write and answers register reads.
`timescale 1ns/1ps
`default_nettype none

module hc_csr import hc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  t_mmio_req   mmio_req,
  output t_mmio_rsp   mmio_rsp,
  input  logic        busy,
  input  logic        done,
  output logic        go,
  output t_hc_control hc_control
);

  t_hc_control ctl;
  t_hc_status  status;
  t_hc_reg     rd_mux;
  logic        rsp_valid;
  t_hc_reg     rsp_data;

  // Status word as seen by software, upper bits read as zero
  always_comb begin
    status      = '0;
    status.busy = busy;
    status.done = done;
  end

  // The control register is write-only, bit 0 kicks off a job in the same cycle
  assign go = mmio_req.wr && (mmio_req.addr == HC_REG_CTRL) && mmio_req.data[0];

  assign hc_control = ctl;

  // Descriptor registers take the write data in the cycle of the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      ctl <= '0;
    end else if (mmio_req.wr) begin
      case (mmio_req.addr)
        HC_REG_DSM: ctl.dsm_base  <= mmio_req.data;
        HC_REG_SRC: ctl.src_base  <= mmio_req.data;
        HC_REG_DST: ctl.dst_base  <= mmio_req.data;
        // Only the low byte of the length register is kept
        HC_REG_LEN: ctl.num_lines <= mmio_req.data[7:0];
        default: ;
      endcase
    end
  end

  // Read mux, unmapped words and the control word read as zero
  always_comb begin
    case (mmio_req.addr)
      HC_REG_DSM:    rd_mux = ctl.dsm_base;
      HC_REG_SRC:    rd_mux = ctl.src_base;
      HC_REG_DST:    rd_mux = ctl.dst_base;
      HC_REG_LEN:    rd_mux = t_hc_reg'(ctl.num_lines);
      HC_REG_STATUS: rd_mux = t_hc_reg'(status);
      default:       rd_mux = '0;
    endcase
  end

  // The answer goes out one cycle after the read strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= mmio_req.rd;
    end
  end

  // Read data is a payload register and only matters while valid is high
  always_ff @(posedge clk) begin
    if (mmio_req.rd) begin
      rsp_data <= rd_mux;
    end
  end

  always_comb begin
    mmio_rsp.valid = rsp_valid;
    mmio_rsp.data  = rsp_data;
  end

endmodule : hc_csr

`default_nettype wire

//--- hdl/hc_loopback.sv
// Loopback processing core.
// Copies the first num_lines input-bank lines to the output bank, then pulses finish.
`timescale 1ns/1ps
`default_nettype none

module hc_loopback import hc_pkg::*; #(
  parameter int BUF_DEPTH = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  t_hc_length num_lines,
  output logic       finish,
  output t_hc_tag    rd_idx,
  input  t_hc_line   rd_data,
  output logic       wr_en,
  output t_hc_tag    wr_idx,
  output t_hc_line   wr_data
);

  t_core_state state;
  t_hc_length  len;
  // Next line to read from the input bank
  t_hc_length  cnt;
  // A read went out last cycle and its data is on rd_data now
  logic        rd_pend;
  t_hc_tag     wr_idx_r;

  // The copy never runs past the end of a bank
  assign len = (num_lines > t_hc_length'(BUF_DEPTH)) ? t_hc_length'(BUF_DEPTH) : num_lines;

  assign rd_idx  = t_hc_tag'(cnt);
  assign wr_en   = rd_pend;
  assign wr_idx  = wr_idx_r;
  assign wr_data = rd_data;
  // Finish lands num_lines + 2 cycles after start, right after the last write
  assign finish  = (state == CORE_DONE);

  always_ff @(posedge clk) begin
    wr_idx_r <= t_hc_tag'(cnt);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= CORE_IDLE;
      cnt     <= '0;
      rd_pend <= 1'b0;
    end else begin
      case (state)
        CORE_IDLE: begin
          rd_pend <= 1'b0;
          if (start) begin
            cnt   <= '0;
            state <= CORE_COPY;
          end
        end
        CORE_COPY: begin
          if (cnt != len) begin
            rd_pend <= 1'b1;
            cnt     <= cnt + 1'b1;
          end else begin
            // The last line is written in this cycle
            rd_pend <= 1'b0;
            state   <= CORE_DONE;
          end
        end
        CORE_DONE: state <= CORE_IDLE;
        default:   state <= CORE_IDLE;
      endcase
    end
  end

endmodule : hc_loopback

`default_nettype wire

//--- hdl/hc_pkg.sv
// Shared types for the host-copy accelerator.
// Holds the line, address and bus structs, the register map and the FSM encodings.
`default_nettype none

package hc_pkg;

  // One cache line of payload
  typedef logic [63:0] t_hc_line;
  // Host line address, consecutive lines sit at consecutive addresses
  typedef logic [31:0] t_hc_address;
  // Read tag, which carries the buffer index of the requested line
  typedef logic [7:0]  t_hc_tag;
  // Job length counted in lines
  typedef logic [7:0]  t_hc_length;
  typedef logic [31:0] t_hc_reg;
  typedef logic [3:0]  t_hc_reg_addr;

  // Status word as software sees it
  typedef struct packed {
    logic [29:0] rsvd;
    logic        done;
    logic        busy;
  } t_hc_status;

  // Job descriptor handed from the register file to the requestor
  typedef struct packed {
    t_hc_address dsm_base;
    t_hc_address src_base;
    t_hc_address dst_base;
    t_hc_length  num_lines;
  } t_hc_control;

  typedef struct packed {
    logic        valid;
    t_hc_address addr;
    t_hc_tag     tag;
  } t_mem_rd_req;

  typedef struct packed {
    logic     valid;
    t_hc_tag  tag;
    t_hc_line data;
  } t_mem_rd_rsp;

  typedef struct packed {
    logic        valid;
    t_hc_address addr;
    t_hc_line    data;
  } t_mem_wr_req;

  typedef struct packed {
    logic         wr;
    logic         rd;
    t_hc_reg_addr addr;
    t_hc_reg      data;
  } t_mmio_req;

  typedef struct packed {
    logic    valid;
    t_hc_reg data;
  } t_mmio_rsp;

  // Register word addresses
  localparam t_hc_reg_addr HC_REG_DSM    = 4'd0;
  localparam t_hc_reg_addr HC_REG_SRC    = 4'd1;
  localparam t_hc_reg_addr HC_REG_DST    = 4'd2;
  localparam t_hc_reg_addr HC_REG_LEN    = 4'd3;
  localparam t_hc_reg_addr HC_REG_CTRL   = 4'd4;
  localparam t_hc_reg_addr HC_REG_STATUS = 4'd5;

  // Completion marker that goes into the upper half of the DSM line
  localparam logic [31:0] HC_DSM_DONE = 32'h0000_d0e0;

  typedef enum logic [2:0] {
    REQ_IDLE, REQ_FETCH, REQ_RUN, REQ_STORE, REQ_DSM, REQ_FINAL
  } t_req_state;

  typedef enum logic [1:0] {
    CORE_IDLE, CORE_COPY, CORE_DONE
  } t_core_state;

endpackage : hc_pkg

`default_nettype wire

//--- hdl/hc_requestor.sv
// Job sequencer of the host-copy accelerator.
// Fetches source lines, runs the core, writes results back and posts the DSM record.
`timescale 1ns/1ps
`default_nettype none

module hc_requestor import hc_pkg::*; #(
  parameter int BUF_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        go,
  input  t_hc_control hc_control,
  output logic        busy,
  output logic        done,
  output t_mem_rd_req rd_req,
  input  t_mem_rd_rsp rd_rsp,
  input  logic        rd_alm_full,
  output t_mem_wr_req wr_req,
  input  logic        wr_ack,
  input  logic        wr_alm_full,
  output logic        in_we,
  output t_hc_tag     in_idx,
  output t_hc_line    in_data,
  output t_hc_tag     out_idx,
  input  t_hc_line    out_data,
  output logic        start,
  output t_hc_length  num_lines,
  input  logic        finish
);

  t_req_state  state;
  t_hc_control job;
  t_hc_length  len;
  t_hc_length  len_clamp;
  // Reads issued and responses seen during FETCH
  t_hc_length  rd_cnt;
  t_hc_length  rsp_cnt;
  t_hc_length  rsp_cnt_n;
  // Next line to write and acks seen during STORE
  t_hc_length  wr_ptr;
  t_hc_length  wr_ptr_n;
  t_hc_length  ack_cnt;
  t_hc_length  ack_cnt_n;
  // Output bank data for line wr_ptr is on out_data
  logic        pipe_valid;
  logic        rd_fire;
  logic        wr_fire;
  logic        dsm_fire;

  // A job never covers more lines than one bank holds
  assign len_clamp = (hc_control.num_lines > t_hc_length'(BUF_DEPTH)) ?
                     t_hc_length'(BUF_DEPTH) : hc_control.num_lines;

  assign busy      = (state != REQ_IDLE);
  assign num_lines = len;

  // Read requests go out one per line, held off while the channel is almost full
  assign rd_fire = (state == REQ_FETCH) && (rd_cnt != len) && !rd_alm_full;

  always_comb begin
    rd_req.valid = rd_fire;
    rd_req.addr  = job.src_base + t_hc_address'(rd_cnt);
    rd_req.tag   = t_hc_tag'(rd_cnt);
  end

  // Responses land in the input bank at the index carried by the tag
  assign in_we     = (state == REQ_FETCH) && rd_rsp.valid;
  assign in_idx    = rd_rsp.tag;
  assign in_data   = rd_rsp.data;
  assign rsp_cnt_n = rsp_cnt + t_hc_length'(in_we);

  // Write-back pipeline
  // out_idx always names the line wanted next cycle so a stall keeps its data
  assign wr_fire   = (state == REQ_STORE) && pipe_valid && !wr_alm_full;
  assign wr_ptr_n  = wr_ptr + t_hc_length'(wr_fire);
  assign out_idx   = t_hc_tag'(wr_ptr_n);
  assign ack_cnt_n = ack_cnt + t_hc_length'((state == REQ_STORE) && wr_ack);
  assign dsm_fire  = (state == REQ_DSM) && !wr_alm_full;

  always_comb begin
    wr_req.valid = wr_fire || dsm_fire;
    if (state == REQ_DSM) begin
      // Completion record carries the marker on top and the length in the low byte
      wr_req.addr = job.dsm_base;
      wr_req.data = {HC_DSM_DONE, 24'd0, len};
    end else begin
      wr_req.addr = job.dst_base + t_hc_address'(wr_ptr);
      wr_req.data = out_data;
    end
  end

  // Descriptor copy, taken only when a job is accepted
  always_ff @(posedge clk) begin
    if ((state == REQ_IDLE) && go) begin
      job <= hc_control;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= REQ_IDLE;
      done       <= 1'b0;
      start      <= 1'b0;
      len        <= '0;
      rd_cnt     <= '0;
      rsp_cnt    <= '0;
      wr_ptr     <= '0;
      ack_cnt    <= '0;
      pipe_valid <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        REQ_IDLE: begin
          // A go while busy never reaches this branch and is dropped
          if (go) begin
            len     <= len_clamp;
            rd_cnt  <= '0;
            rsp_cnt <= '0;
            wr_ptr  <= '0;
            ack_cnt <= '0;
            done    <= 1'b0;
            state   <= REQ_FETCH;
          end
        end
        REQ_FETCH: begin
          rd_cnt  <= rd_cnt + t_hc_length'(rd_fire);
          rsp_cnt <= rsp_cnt_n;
          // Every tag has come back, so the input bank is complete
          if (rsp_cnt_n == len) begin
            start <= 1'b1;
            state <= REQ_RUN;
          end
        end
        REQ_RUN: begin
          // Line 0 of the output bank is being read in this cycle
          if (finish) begin
            pipe_valid <= (len != '0);
            state      <= REQ_STORE;
          end
        end
        REQ_STORE: begin
          wr_ptr     <= wr_ptr_n;
          ack_cnt    <= ack_cnt_n;
          pipe_valid <= (wr_ptr_n != len);
          // The DSM write waits until every data write is acked
          if (ack_cnt_n == len) begin
            state <= REQ_DSM;
          end
        end
        REQ_DSM: begin
          if (dsm_fire) begin
            state <= REQ_FINAL;
          end
        end
        REQ_FINAL: begin
          if (wr_ack) begin
            done  <= 1'b1;
            state <= REQ_IDLE;
          end
        end
        default: state <= REQ_IDLE;
      endcase
    end
  end

endmodule : hc_requestor

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_hc_afu \
  -f src.f \
  -o Vtb_hc_afu

# The pipe status is the one of tee, the log decides the outcome
./obj_dir/Vtb_hc_afu 2>&1 | tee sim.log

if grep -q "TEST PASS" sim.log; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

//--- src.f
hdl/hc_pkg.sv
hdl/hc_csr.sv
hdl/hc_requestor.sv
hdl/hc_core_buffer.sv
hdl/hc_loopback.sv
hdl/hc_afu_top.sv
bench/tb_hc_afu.sv
